// ==== compile.f ====
+incdir+.
game_geom_pkg.sv
game_ctrl_pkg.sv
drop_fsm.sv
drop_counter.sv
player_ball.sv
collision_check.sv
ball_table.sv
ball_drop_top.sv
ball_drop_sva.sv
ball_drop_checker.sv
tb_ball_drop.sv

// ==== tb_ball_drop.sv ====
`default_nettype none

`include "game_macros.svh"

module tb_ball_drop;

    localparam int N_ENTRIES   = 8;
    localparam int EXP_TESTS   = N_ENTRIES + 4; // placements, two resets, two game ends
    localparam int MAX_MOVE    = 75;
    localparam int CYCLE_LIMIT = N_ENTRIES *
                                 (MAX_MOVE + `FIELD_FLOOR / `FALL_STEP + `HIT_LIMIT + 8);

    typedef struct packed {
        logic [7:0] left_cycles;
        logic [7:0] right_cycles;
        logic       reset_before;
        logic       exp_finish;
    } entry_t;

    // left cycles, right cycles, reset first, finish expected at game end
    // holds of 60 run into a wall and get a random extra
    entry_t entries [N_ENTRIES] = '{
        '{8'd0,  8'd0,  1'b0, 1'b0},  // centred stack
        '{8'd0,  8'd0,  1'b0, 1'b0},
        '{8'd0,  8'd0,  1'b0, 1'b0},
        '{8'd0,  8'd0,  1'b0, 1'b0},
        '{8'd60, 8'd0,  1'b1, 1'b1},  // spread game
        '{8'd0,  8'd60, 1'b0, 1'b1},
        '{8'd30, 8'd0,  1'b0, 1'b1},  // off-centre onto ball 0
        '{8'd0,  8'd0,  1'b0, 1'b1}
    };

    logic                       clk;
    logic                       rst;
    game_ctrl_pkg::player_cmd_t cmd;
    game_geom_pkg::ball_t       active;
    game_geom_pkg::ball_table_t slots;
    game_geom_pkg::slot_idx_t   ball_count;
    game_ctrl_pkg::drop_state_t state;
    logic                       game_over;
    logic                       finish;
    logic                       exp_finish;
    int                         error_count;
    int                         test_count;
    int                         cycle_count = 0;

    ball_drop_top ball_drop_top_i (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .active     (active),
        .slots      (slots),
        .ball_count (ball_count),
        .state      (state),
        .game_over  (game_over),
        .finish     (finish)
    );

    ball_drop_checker check_i (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .active      (active),
        .slots       (slots),
        .ball_count  (ball_count),
        .state       (state),
        .game_over   (game_over),
        .finish      (finish),
        .exp_finish  (exp_finish),
        .error_count (error_count),
        .test_count  (test_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic hold_cmd(input game_ctrl_pkg::player_cmd_t c, input int cycles);
        cmd = c;
        repeat (cycles) @(negedge clk);
        cmd = '0;
    endtask

    // one drop pulse, then until the ball is placed
    task automatic drop_and_wait();
        game_geom_pkg::slot_idx_t start;
        start = ball_count;
        hold_cmd('{left: 1'b0, right: 1'b0, drop: 1'b1}, 1);
        while (ball_count == start && !game_over) begin
            @(negedge clk);
        end
    endtask

    initial begin
        cmd        = '0;
        rst        = 1'b1;
        exp_finish = 1'b0;
        void'($urandom(32'haacaf794));
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (entries[i].left_cycles >= 60) entries[i].left_cycles += 8'($urandom % 16);
            if (entries[i].right_cycles >= 60) entries[i].right_cycles += 8'($urandom % 16);
        end
        apply_reset();
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (entries[i].reset_before) apply_reset();
            exp_finish = entries[i].exp_finish;
            hold_cmd('{left: 1'b1, right: 1'b0, drop: 1'b0}, entries[i].left_cycles);
            hold_cmd('{left: 1'b0, right: 1'b1, drop: 1'b0}, entries[i].right_cycles);
            drop_and_wait();
        end
        repeat (2) @(negedge clk);
        $display("checks: %0d, errors: %0d, assertion failures: %0d", test_count,
                 error_count, ball_drop_top_i.sva_i.fail_count);
        if (test_count != EXP_TESTS) begin
            $display("only %0d of %0d checks were run", test_count, EXP_TESTS);
        end
        if (error_count == 0 && ball_drop_top_i.sva_i.fail_count == 0 &&
            test_count == EXP_TESTS) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ball_drop_checker.sv ====
`default_nettype none

`include "game_macros.svh"

module ball_drop_checker (
    input  wire                               clk,
    input  wire                               rst,
    input  wire game_ctrl_pkg::player_cmd_t   cmd,
    input  wire game_geom_pkg::ball_t         active,
    input  wire game_geom_pkg::ball_table_t   slots,
    input  wire game_geom_pkg::slot_idx_t     ball_count,
    input  wire game_ctrl_pkg::drop_state_t   state,
    input  wire                               game_over,
    input  wire                               finish,
    input  wire                               exp_finish,
    output int                                error_count,
    output int                                test_count
);

    game_ctrl_pkg::drop_state_t m_state;
    int m_x;
    int m_y;
    int m_r;
    int m_count;
    int m_hits;
    int s_x [`MAX_BALLS];
    int s_y [`MAX_BALLS];
    int s_r [`MAX_BALLS];
    bit s_v [`MAX_BALLS];
    bit in_reset;
    bit reset_checked;
    bit last_over;
    int last_count;

    initial begin
        error_count = 0;
        test_count  = 0;
    end

    function automatic int radius_seq(input int n);
        case (n % 4)
            0:       return `RADIUS_L;
            1:       return `RADIUS_M;
            2:       return `RADIUS_S;
            default: return `RADIUS_XL;
        endcase
    endfunction

    task automatic spawn();
        m_r = radius_seq(m_count);
        m_x = `SPAWN_X;
        m_y = `FIELD_TOP - m_r;
    endtask

    // pushes from every placed ball the active one touches
    task automatic probe(output int n_left, output int n_right, output bit aligned);
        int dx;
        int dy;
        int rs;
        n_left  = 0;
        n_right = 0;
        aligned = 1'b0;
        for (int i = 0; i < `MAX_BALLS; i++) begin
            dx = m_x - s_x[i];
            dy = m_y - s_y[i];
            rs = m_r + s_r[i];
            if (s_v[i] && dx * dx + dy * dy <= rs * rs) begin
                n_left  += (dx < 0);
                n_right += (dx > 0);
                aligned |= (dx == 0);
            end
        end
    endtask

    function automatic bit model_finish();
        bit ovf;
        ovf = 1'b0;
        for (int i = 0; i < `MAX_BALLS; i++) begin
            if (s_v[i] && s_y[i] - s_r[i] < `FIELD_TOP) ovf = 1'b1;
        end
        return (m_state == game_ctrl_pkg::over) && !ovf;
    endfunction

    always @(posedge clk) begin : model
        int n_left;
        int n_right;
        bit aligned;
        bit at_wall;
        int floor_y;
        in_reset = rst;
        if (rst) begin
            m_state = game_ctrl_pkg::aim;
            m_count = 0;
            m_hits  = 0;
            for (int i = 0; i < `MAX_BALLS; i++) begin
                s_v[i] = 1'b0;
            end
            spawn();
        end else begin
            case (m_state)
                game_ctrl_pkg::aim: begin
                    if (cmd.drop) begin
                        m_state = game_ctrl_pkg::fall;
                    end else if (cmd.left) begin
                        if (m_x > `FIELD_LEFT + m_r) m_x--;
                    end else if (cmd.right && m_x < `FIELD_RIGHT - m_r) begin
                        m_x++;
                    end
                end
                game_ctrl_pkg::fall: begin
                    probe(n_left, n_right, aligned);
                    floor_y = `FIELD_FLOOR - m_r;
                    at_wall = (m_x == `FIELD_LEFT + m_r) || (m_x == `FIELD_RIGHT - m_r);
                    if (!aligned && n_left + n_right == 0) begin
                        if (m_y == floor_y) m_state = game_ctrl_pkg::place;
                        m_y = (m_y + `FALL_STEP > floor_y) ? floor_y : m_y + `FALL_STEP;
                    end else begin
                        if (aligned || n_left == n_right || at_wall ||
                            m_hits == `HIT_LIMIT || m_y == floor_y) begin
                            m_state = game_ctrl_pkg::place;
                        end
                        if (!aligned && n_left != n_right && !at_wall) begin
                            m_x += (n_left > n_right) ? -1 : 1; // away from the crowd
                        end
                        if (m_hits < `HIT_LIMIT) m_hits++;
                    end
                end
                game_ctrl_pkg::place: begin
                    s_v[m_count] = 1'b1;
                    s_x[m_count] = m_x;
                    s_y[m_count] = m_y;
                    s_r[m_count] = m_r;
                    m_count++;
                    m_hits = 0;
                    spawn();
                    if (m_count == `MAX_BALLS) m_state = game_ctrl_pkg::over;
                    else m_state = game_ctrl_pkg::aim;
                end
                default: ;
            endcase
        end
    end

    task automatic compare_field(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("[ERROR] %s: got %0h expected %0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = error_count;
        compare_field("ball_count", ball_count, 0);
        compare_field("state", state, game_ctrl_pkg::aim);
        for (int i = 0; i < `MAX_BALLS; i++) begin
            compare_field($sformatf("slots[%0d].valid", i), slots[i].valid, 0);
        end
        compare_field("active.x", active.x, `SPAWN_X);
        compare_field("active.y", active.y, `FIELD_TOP - `RADIUS_L);
        compare_field("active.radius", active.radius, `RADIUS_L);
        compare_field("game_over", game_over, 0);
        compare_field("finish", finish, 0);
        test_count++;
        $display("reset state: %s", (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic check_slot(input int idx);
        int errs_before;
        errs_before = error_count;
        compare_field("ball_count", ball_count, m_count);
        compare_field("state", state, m_state);
        compare_field($sformatf("slots[%0d].valid", idx), slots[idx].valid, s_v[idx]);
        compare_field($sformatf("slots[%0d].x", idx), slots[idx].x, s_x[idx]);
        compare_field($sformatf("slots[%0d].y", idx), slots[idx].y, s_y[idx]);
        compare_field($sformatf("slots[%0d].radius", idx), slots[idx].radius, s_r[idx]);
        test_count++;
        $display("ball %0d placed at x=%0d y=%0d r=%0d: %s", idx, s_x[idx], s_y[idx],
                 s_r[idx], (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    task automatic check_finish();
        int errs_before;
        errs_before = error_count;
        compare_field("game_over", game_over, m_state == game_ctrl_pkg::over);
        compare_field("state", state, m_state);
        compare_field("finish", finish, model_finish());
        compare_field("finish vs table", finish, exp_finish);
        test_count++;
        $display("game over, finish=%0d: %s", finish,
                 (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (in_reset) begin
            if (!reset_checked) check_reset();
            reset_checked = 1'b1;
            last_count    = 0;
            last_over     = 1'b0;
        end else begin
            reset_checked = 1'b0;
            if (int'(ball_count) != last_count) begin
                check_slot(last_count);
                last_count = ball_count;
            end
            if (game_over && !last_over) check_finish();
            last_over = game_over;
        end
    end

endmodule

`default_nettype wire

// ==== ball_drop_sva.sv ====
`default_nettype none

`include "game_macros.svh"

module ball_drop_sva (
    input wire                               clk,
    input wire                               rst,
    input wire game_ctrl_pkg::drop_state_t   state,
    input wire game_geom_pkg::slot_idx_t     ball_count,
    input wire game_geom_pkg::ball_t         active
);

    int fail_count = 0;

    place_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        state == game_ctrl_pkg::place |=> state != game_ctrl_pkg::place
    ) else begin
        $error("place state held longer than one cycle");
        fail_count++;
    end

    count_bound: assert property (
        @(posedge clk) disable iff (rst) ball_count <= `MAX_BALLS
    ) else begin
        $error("ball_count above the table size");
        fail_count++;
    end

    // centre kept one radius off each wall
    x_in_walls: assert property (
        @(posedge clk) disable iff (rst)
        active.x >= `FIELD_LEFT + active.radius && active.x <= `FIELD_RIGHT - active.radius
    ) else begin
        $error("active ball outside the walls");
        fail_count++;
    end

endmodule

bind ball_drop_top ball_drop_sva sva_i (
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .ball_count (ball_count),
    .active     (active)
);

`default_nettype wire

// ==== ball_drop_top.sv ====
`default_nettype none

module ball_drop_top (
    input  wire                               clk,
    input  wire                               rst,
    input  wire game_ctrl_pkg::player_cmd_t   cmd,
    output game_geom_pkg::ball_t              active,
    output game_geom_pkg::ball_table_t        slots,
    output game_geom_pkg::slot_idx_t          ball_count,
    output game_ctrl_pkg::drop_state_t        state,
    output logic                              game_over,
    output logic                              finish
);

    game_geom_pkg::nudge_t nudge;
    logic                  hit;
    logic                  at_floor;
    logic                  at_wall;
    logic                  budget_out;
    logic                  table_full;
    logic                  overflow;

    drop_fsm u_drop_fsm (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .nudge      (nudge),
        .at_floor   (at_floor),
        .at_wall    (at_wall),
        .budget_out (budget_out),
        .table_full (table_full),
        .state      (state)
    );

    drop_counter u_drop_counter (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .hit        (hit),
        .ball_count (ball_count),
        .table_full (table_full),
        .budget_out (budget_out)
    );

    player_ball u_player_ball (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .cmd        (cmd),
        .nudge      (nudge),
        .ball_count (ball_count),
        .active     (active),
        .at_floor   (at_floor),
        .at_wall    (at_wall)
    );

    collision_check u_collision_check (
        .active (active),
        .slots  (slots),
        .hit    (hit),
        .nudge  (nudge)
    );

    ball_table u_ball_table (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .ball_count (ball_count),
        .active     (active),
        .slots      (slots),
        .overflow   (overflow)
    );

    assign game_over = (state == game_ctrl_pkg::over);
    assign finish    = game_over && !overflow;

endmodule

`default_nettype wire

// ==== ball_table.sv ====
`default_nettype none

`include "game_macros.svh"

module ball_table (
    input  wire                               clk,
    input  wire                               rst,
    input  wire game_ctrl_pkg::drop_state_t   state,
    input  wire game_geom_pkg::slot_idx_t     ball_count,
    input  wire game_geom_pkg::ball_t         active,
    output game_geom_pkg::ball_table_t        slots,
    output logic                              overflow
);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MAX_BALLS; i++) begin
                slots[i].valid <= 1'b0;
            end
        end else if (state == game_ctrl_pkg::place) begin
            for (int i = 0; i < `MAX_BALLS; i++) begin
                if (game_geom_pkg::slot_idx_t'(i) == ball_count) begin
                    slots[i] <= active; // next free slot
                end
            end
        end
    end

    // top edge of a stored ball above the top line
    always_comb begin
        overflow = 1'b0;
        for (int i = 0; i < `MAX_BALLS; i++) begin
            if (slots[i].valid &&
                slots[i].y < game_geom_pkg::coord_t'(`FIELD_TOP) +
                             game_geom_pkg::coord_t'(slots[i].radius)) begin
                overflow = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== collision_check.sv ====
`default_nettype none

`include "game_macros.svh"

module collision_check (
    input  wire game_geom_pkg::ball_t         active,
    input  wire game_geom_pkg::ball_table_t   slots,
    output logic                              hit,
    output game_geom_pkg::nudge_t             nudge
);

    localparam int CNT_W = $clog2(`MAX_BALLS + 1);

    logic [`MAX_BALLS-1:0] slot_hit;
    logic [`MAX_BALLS-1:0] push_left;
    logic [`MAX_BALLS-1:0] push_right;
    logic [`MAX_BALLS-1:0] aligned;
    logic [CNT_W-1:0]      n_left;
    logic [CNT_W-1:0]      n_right;

    for (genvar i = 0; i < `MAX_BALLS; i++) begin : g_slot
        game_geom_pkg::coord_t dx;
        game_geom_pkg::coord_t dy;
        logic [6:0]            rsum;
        game_geom_pkg::dist_t  d2;
        game_geom_pkg::dist_t  r2;

        assign dx = (active.x >= slots[i].x) ? active.x - slots[i].x
                                             : slots[i].x - active.x;
        assign dy = (active.y >= slots[i].y) ? active.y - slots[i].y
                                             : slots[i].y - active.y;
        assign rsum = {1'b0, active.radius} + {1'b0, slots[i].radius};

        assign d2 = game_geom_pkg::dist_t'(dx) * game_geom_pkg::dist_t'(dx) +
                    game_geom_pkg::dist_t'(dy) * game_geom_pkg::dist_t'(dy);
        assign r2 = game_geom_pkg::dist_t'(rsum) * game_geom_pkg::dist_t'(rsum);

        assign slot_hit[i]   = slots[i].valid && (d2 <= r2);
        // pushed away from the placed ball
        assign push_left[i]  = slot_hit[i] && (active.x < slots[i].x);
        assign push_right[i] = slot_hit[i] && (active.x > slots[i].x);
        assign aligned[i]    = slot_hit[i] && (active.x == slots[i].x);
    end

    always_comb begin
        n_left  = '0;
        n_right = '0;
        for (int i = 0; i < `MAX_BALLS; i++) begin
            n_left  = n_left + CNT_W'(push_left[i]);
            n_right = n_right + CNT_W'(push_right[i]);
        end
    end

    assign hit = |slot_hit;

    always_comb begin
        if (!hit) begin
            nudge = game_geom_pkg::none;
        end else if ((|aligned) || (n_left == n_right)) begin
            nudge = game_geom_pkg::stuck; // no net push
        end else if (n_left > n_right) begin
            nudge = game_geom_pkg::left;
        end else begin
            nudge = game_geom_pkg::right;
        end
    end

endmodule

`default_nettype wire

// ==== player_ball.sv ====
`default_nettype none

`include "game_macros.svh"

module player_ball (
    input  wire                               clk,
    input  wire                               rst,
    input  wire game_ctrl_pkg::drop_state_t   state,
    input  wire game_ctrl_pkg::player_cmd_t   cmd,
    input  wire game_geom_pkg::nudge_t        nudge,
    input  wire game_geom_pkg::slot_idx_t     ball_count,
    output game_geom_pkg::ball_t              active,
    output logic                              at_floor,
    output logic                              at_wall
);

    game_geom_pkg::coord_t  rad;
    game_geom_pkg::coord_t  left_x;
    game_geom_pkg::coord_t  right_x;
    game_geom_pkg::coord_t  floor_y;
    game_geom_pkg::coord_t  fall_y;
    game_geom_pkg::radius_t next_rad;

    // size sequence L, M, S, XL by slot index
    function automatic game_geom_pkg::radius_t size_of(input game_geom_pkg::slot_idx_t idx);
        case (idx[1:0])
            2'd0:    size_of = game_geom_pkg::radius_t'(`RADIUS_L);
            2'd1:    size_of = game_geom_pkg::radius_t'(`RADIUS_M);
            2'd2:    size_of = game_geom_pkg::radius_t'(`RADIUS_S);
            default: size_of = game_geom_pkg::radius_t'(`RADIUS_XL);
        endcase
    endfunction

    assign rad      = game_geom_pkg::coord_t'(active.radius);
    assign left_x   = game_geom_pkg::coord_t'(`FIELD_LEFT) + rad;
    assign right_x  = game_geom_pkg::coord_t'(`FIELD_RIGHT) - rad;
    assign floor_y  = game_geom_pkg::coord_t'(`FIELD_FLOOR) - rad;
    assign fall_y   = active.y + game_geom_pkg::coord_t'(`FALL_STEP);
    assign next_rad = size_of(ball_count + 1'b1);

    assign at_wall  = (active.x == left_x) || (active.x == right_x);
    assign at_floor = (active.y == floor_y);

    always_ff @(posedge clk) begin
        if (rst) begin
            active.valid  <= 1'b1;
            active.x      <= game_geom_pkg::coord_t'(`SPAWN_X);
            active.y      <= game_geom_pkg::coord_t'(`FIELD_TOP) -
                             game_geom_pkg::coord_t'(size_of('0));
            active.radius <= size_of('0);
        end else begin
            case (state)
                game_ctrl_pkg::aim: begin
                    if (!cmd.drop) begin // drop keeps x
                        if (cmd.left) begin
                            if (active.x != left_x) begin
                                active.x <= active.x - 1'b1;
                            end
                        end else if (cmd.right && active.x != right_x) begin
                            active.x <= active.x + 1'b1;
                        end
                    end
                end
                game_ctrl_pkg::fall: begin
                    if (nudge == game_geom_pkg::none) begin
                        active.y <= (fall_y >= floor_y) ? floor_y : fall_y;
                    end else if (!at_wall) begin
                        // y holds while touching
                        if (nudge == game_geom_pkg::left) begin
                            active.x <= active.x - 1'b1;
                        end else if (nudge == game_geom_pkg::right) begin
                            active.x <= active.x + 1'b1;
                        end
                    end
                end
                game_ctrl_pkg::place: begin
                    active.valid  <= 1'b1;
                    active.x      <= game_geom_pkg::coord_t'(`SPAWN_X);
                    active.y      <= game_geom_pkg::coord_t'(`FIELD_TOP) -
                                     game_geom_pkg::coord_t'(next_rad);
                    active.radius <= next_rad;
                end
                default: begin
                    active <= active;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== drop_counter.sv ====
`default_nettype none

`include "game_macros.svh"

module drop_counter (
    input  wire                               clk,
    input  wire                               rst,
    input  wire game_ctrl_pkg::drop_state_t   state,
    input  wire                               hit,
    output game_geom_pkg::slot_idx_t          ball_count,
    output logic                              table_full,
    output logic                              budget_out
);

    localparam int HIT_W = $clog2(`HIT_LIMIT + 1);

    logic [HIT_W-1:0] hit_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            ball_count <= '0;
        end else if (state == game_ctrl_pkg::place) begin
            ball_count <= ball_count + 1'b1;
        end
    end

    // collision cycles of the current fall, saturating
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_cnt <= '0;
        end else if (state == game_ctrl_pkg::place) begin
            hit_cnt <= '0;
        end else if (state == game_ctrl_pkg::fall && hit && !budget_out) begin
            hit_cnt <= hit_cnt + 1'b1;
        end
    end

    assign budget_out = (hit_cnt == HIT_W'(`HIT_LIMIT));
    // this placement takes the last slot
    assign table_full = (ball_count == game_geom_pkg::slot_idx_t'(`MAX_BALLS - 1));

endmodule

`default_nettype wire

// ==== drop_fsm.sv ====
`default_nettype none

module drop_fsm (
    input  wire                               clk,
    input  wire                               rst,
    input  wire game_ctrl_pkg::player_cmd_t   cmd,
    input  wire game_geom_pkg::nudge_t        nudge,
    input  wire                               at_floor,
    input  wire                               at_wall,
    input  wire                               budget_out,
    input  wire                               table_full,
    output game_ctrl_pkg::drop_state_t        state
);

    game_ctrl_pkg::drop_state_t state_next;
    logic                       hit_rest;

    // colliding and unable to keep sliding
    assign hit_rest = (nudge == game_geom_pkg::stuck) ||
                      ((nudge != game_geom_pkg::none) && (at_wall || budget_out));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= game_ctrl_pkg::aim;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            game_ctrl_pkg::aim: begin
                if (cmd.drop) begin
                    state_next = game_ctrl_pkg::fall;
                end
            end
            game_ctrl_pkg::fall: begin
                if (at_floor || hit_rest) begin
                    state_next = game_ctrl_pkg::place;
                end
            end
            game_ctrl_pkg::place: begin
                // single cycle, slot written here
                if (table_full) begin
                    state_next = game_ctrl_pkg::over;
                end else begin
                    state_next = game_ctrl_pkg::aim;
                end
            end
            default: begin
                state_next = game_ctrl_pkg::over; // held until reset
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== game_ctrl_pkg.sv ====
`default_nettype none

package game_ctrl_pkg;

    typedef enum logic [1:0] {
        aim,
        fall,
        place,
        over
    } drop_state_t;

    // player buttons, one bit each
    typedef struct packed {
        logic left;
        logic right;
        logic drop;
    } player_cmd_t;

endpackage

`default_nettype wire

// ==== game_geom_pkg.sv ====
`default_nettype none

`include "game_macros.svh"

package game_geom_pkg;

    typedef logic [`COORD_W-1:0]             coord_t;
    typedef logic [5:0]                      radius_t;
    typedef logic [2*`COORD_W:0]             dist_t;     // squared distance
    typedef logic [$clog2(`MAX_BALLS+1)-1:0] slot_idx_t;

    typedef struct packed {
        logic    valid;
        coord_t  x;
        coord_t  y;
        radius_t radius;
    } ball_t;

    typedef ball_t [`MAX_BALLS-1:0] ball_table_t;

    // sideways push on the active ball
    typedef enum logic [1:0] {
        none,
        left,
        right,
        stuck
    } nudge_t;

endpackage

`default_nettype wire

// ==== game_macros.svh ====
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// walls and floor of the field, in pixels
`define FIELD_LEFT   20
`define FIELD_RIGHT  120
`define FIELD_TOP    30
`define FIELD_FLOOR  120

`define SPAWN_X      70
`define FALL_STEP    3   // pixels per clock

`define MAX_BALLS    4
`define HIT_LIMIT    100 // collision cycles allowed per fall

// ball radii, used in the order L, M, S, XL
`define RADIUS_S     5
`define RADIUS_M     10
`define RADIUS_L     15
`define RADIUS_XL    20

`define COORD_W      12

`endif
